/* bench/router_tb_table.svh */
// Worm stimulus table for the look-ahead router testbench
`ifndef ROUTER_TB_TABLE_SVH
`define ROUTER_TB_TABLE_SVH

// Columns: test name, input port, destination x, worm length, expected output,
// sent together with the next row, downstream credits withheld on the output
localparam int NUM_TESTS = 14;

task automatic load_tests();
    tests[0]  = '{"local_x3_single", `ROUTER_PORT_LOCAL, 3, 1, `ROUTER_PORT_EAST, 1'b0, 1'b0};
    tests[1]  = '{"local_x5_single", `ROUTER_PORT_LOCAL, 5, 1, `ROUTER_PORT_EAST, 1'b0, 1'b0};
    tests[2]  = '{"east_x2_single", `ROUTER_PORT_EAST, 2, 1, `ROUTER_PORT_LOCAL, 1'b0, 1'b0};
    tests[3]  = '{"west_x4_multi", `ROUTER_PORT_WEST, 4, 5, `ROUTER_PORT_EAST, 1'b0, 1'b0};
    tests[4]  = '{"east_x0_multi", `ROUTER_PORT_EAST, 0, 4, `ROUTER_PORT_WEST, 1'b0, 1'b0};
    tests[5]  = '{"local_x1_multi", `ROUTER_PORT_LOCAL, 1, 3, `ROUTER_PORT_WEST, 1'b0, 1'b0};
    // Contended pairs on the local output
    tests[6]  = '{"contend_a", `ROUTER_PORT_EAST, 2, 3, `ROUTER_PORT_LOCAL, 1'b1, 1'b0};
    tests[7]  = '{"contend_a", `ROUTER_PORT_WEST, 2, 3, `ROUTER_PORT_LOCAL, 1'b0, 1'b0};
    tests[8]  = '{"contend_b", `ROUTER_PORT_EAST, 2, 2, `ROUTER_PORT_LOCAL, 1'b1, 1'b0};
    tests[9]  = '{"contend_b", `ROUTER_PORT_WEST, 2, 4, `ROUTER_PORT_LOCAL, 1'b0, 1'b0};
    tests[10] = '{"contend_c", `ROUTER_PORT_EAST, 2, 1, `ROUTER_PORT_LOCAL, 1'b1, 1'b0};
    tests[11] = '{"contend_c", `ROUTER_PORT_WEST, 2, 3, `ROUTER_PORT_LOCAL, 1'b0, 1'b0};
    // Back-pressure, then a worm after credits resume
    tests[12] = '{"hold_east", `ROUTER_PORT_LOCAL, 6, 7, `ROUTER_PORT_EAST, 1'b0, 1'b1};
    tests[13] = '{"local_x0_after", `ROUTER_PORT_LOCAL, 0, 2, `ROUTER_PORT_WEST, 1'b0, 1'b0};
endtask

`endif

/* bench/router_tb.sv */
// Testbench for the look-ahead router with credit models and worm scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module router_tb;
    import router_pkg::*;

    typedef struct {
        string name;
        int    in_port;
        int    dest_x;
        int    len;
        int    out_port;
        bit    together;
        bit    hold;
    } test_t;

    localparam int POS_X = 2;

    logic       clk;
    logic       rst;
    logic       started;
    xy_t        position;
    flit_t      flit_drv [3];
    flit_t      flit_out [3];
    logic       valid_drv [3];
    logic [2:0] flit_valid;
    logic [2:0] flit_valid_o;
    logic [2:0] credit_o;
    logic [2:0] credit_in;
    logic [2:0] hold;
    logic [7:0] lfsr;
    string      cur_name;
    test_t      tests [14];
    // Worm records, index 0 means no worm
    int         w_in [32];
    int         w_dest [32];
    int         w_len [32];
    int         w_out [32];
    bit         w_pair [32];
    int         n_worms;
    int         expected;
    int         received;
    int         sent [3];
    int         pulses [3];
    int         open_id [3];
    int         idx [3];
    int         out_cnt [3];
    int         last_due [3];
    int         due_list [3][256];
    int         due_wr [3];
    int         due_rd [3];
    // Input that opened the most recent worm on each output
    int         last_winner [3];
    int         cycle;

    `include "router_tb_table.svh"

    assign position   = '{x: 3'd2, y: 3'd0};
    assign flit_valid = {valid_drv[2], valid_drv[1], valid_drv[0]};

    lookahead_router u_lookahead_router (
        .clk (clk), .rst (rst), .position_i (position),
        .flit_east_i (flit_drv[0]), .flit_west_i (flit_drv[1]), .flit_local_i (flit_drv[2]),
        .flit_valid_i (flit_valid), .credit_o (credit_o),
        .flit_east_o (flit_out[0]), .flit_west_o (flit_out[1]), .flit_local_o (flit_out[2]),
        .flit_valid_o (flit_valid_o), .credit_i (credit_in)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Routing rules and worm contents
    //////////////////////////////////////////////////////////////////////

    function automatic direction_t this_hop(int dest);
        direction_t d;
        d = '0;
        if (dest == POS_X) d[`ROUTER_PORT_LOCAL] = 1'b1;
        else if (dest > POS_X) d[`ROUTER_PORT_EAST] = 1'b1;
        else d[`ROUTER_PORT_WEST] = 1'b1;
        return d;
    endfunction

    // Route taken in the tile the worm enters next
    function automatic direction_t next_hop(int dest);
        direction_t d;
        int nb;
        d = '0;
        nb = (dest > POS_X) ? POS_X + 1 : POS_X - 1;
        if (dest == POS_X || dest == nb) d[`ROUTER_PORT_LOCAL] = 1'b1;
        else if (dest > nb) d[`ROUTER_PORT_EAST] = 1'b1;
        else d[`ROUTER_PORT_WEST] = 1'b1;
        return d;
    endfunction

    function automatic flit_t worm_flit(int id, int k, bit at_out);
        flit_t f;
        f.raw = {1'b0, k == w_len[id] - 1, 8'(id), 8'(k), 16'hc3a0 ^ 16'(id * 37 + k)};
        if (k == 0) begin
            f.header.preamble.head = 1'b1;
            f.header.source        = '{x: 3'(w_in[id]), y: 3'd0};
            f.header.destination   = '{x: 3'(w_dest[id]), y: 3'd0};
            f.header.message       = 5'(id);
            f.header.routing       = at_out ? next_hop(w_dest[id]) : this_hop(w_dest[id]);
        end
        return f;
    endfunction

    function automatic int add_worm(int t, bit pair);
        n_worms++;
        w_in[n_worms]   = tests[t].in_port;
        w_dest[n_worms] = tests[t].dest_x;
        w_len[n_worms]  = tests[t].len;
        w_out[n_worms]  = tests[t].out_port;
        w_pair[n_worms] = pair;
        expected += tests[t].len;
        return n_worms;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Upstream sender, downstream credits and scoreboard
    //////////////////////////////////////////////////////////////////////

    task automatic send_worm(int id);
        int p;
        int tmo;
        p = w_in[id];
        for (int k = 0; k < w_len[id]; k++) begin
            tmo = 0;
            // Upstream credits are the depth minus flits not yet credited back
            while (`ROUTER_QUEUE_DEPTH - (sent[p] - pulses[p]) == 0) begin
                @(posedge clk);
                #1;
                tmo++;
                assert (tmo < 200) else fail_now("timed out waiting for an upstream credit");
            end
            flit_drv[p]  = worm_flit(id, k, 1'b0);
            valid_drv[p] = 1'b1;
            sent[p]++;
            @(posedge clk);
            #1;
            valid_drv[p] = 1'b0;
        end
    endtask

    task automatic check_flit(int p);
        flit_t f;
        flit_t exp;
        int    id;
        int    due;
        f = flit_out[p];
        if (open_id[p] == 0) begin
            id = int'(f.header.message);
            assert (f.header.preamble.head && id > 0 && id <= n_worms && w_out[id] == p)
                else fail_now($sformatf("flit %h left output %0d with no worm for it", f.raw, p));
            open_id[p] = id;
            idx[p] = 0;
            // A contended head goes to the input that did not open the last worm here
            if (w_pair[id]) begin
                assert (w_in[id] != last_winner[p])
                    else fail_now($sformatf("input %0d took output %0d out of round-robin turn",
                        w_in[id], p));
            end
            last_winner[p] = w_in[id];
        end
        id  = open_id[p];
        exp = worm_flit(id, idx[p], 1'b1);
        assert (f.raw == exp.raw)
            else fail_now($sformatf("** Error %s: expected %h actual %h", cur_name, exp.raw, f.raw));
        idx[p]++;
        if (idx[p] == w_len[id]) open_id[p] = 0;
        received++;
        out_cnt[p]++;
        // Credit goes back 0 to 3 cycles later, one pulse per cycle at most
        due = cycle + 1 + rand_bits(2);
        if (due <= last_due[p]) due = last_due[p] + 1;
        last_due[p] = due;
        due_list[p][due_wr[p]] = due;
        due_wr[p]++;
    endtask

    initial begin
        credit_in = '0;
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
            #1;
            for (int p = 0; p < 3; p++) begin
                credit_in[p] = 1'b0;
                if (!hold[p] && due_rd[p] != due_wr[p] && due_list[p][due_rd[p]] <= cycle) begin
                    credit_in[p] = 1'b1;
                    due_rd[p]++;
                end
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                assert (started || (flit_valid_o == '0 && credit_o == '0))
                    else fail_now("router outputs were active before any stimulus");
                for (int p = 0; p < 3; p++) begin
                    if (credit_o[p]) pulses[p]++;
                    if (flit_valid_o[p]) check_flit(p);
                end
            end
        end
    end

    function automatic bit drained();
        bit ok;
        ok = (received == expected);
        for (int p = 0; p < 3; p++) begin
            ok = ok && sent[p] == pulses[p] && due_rd[p] == due_wr[p];
        end
        return ok;
    endfunction

    task automatic wait_idle();
        int tmo;
        tmo = 0;
        while (!drained()) begin
            @(posedge clk);
            tmo++;
            assert (tmo < 500) else fail_now("timed out waiting for worms and credits to drain");
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test loop
    //////////////////////////////////////////////////////////////////////

    initial begin
        int i;
        int id_a;
        int id_b;
        int base;
        rst = 1'b1;
        started = 1'b0;
        hold = '0;
        lfsr = 8'd59;
        for (int p = 0; p < 3; p++) begin
            flit_drv[p]    = '0;
            valid_drv[p]   = 1'b0;
            last_winner[p] = -1;
        end
        load_tests();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        repeat (4) @(posedge clk);
        #1 started = 1'b1;
        i = 0;
        while (i < NUM_TESTS) begin
            cur_name = tests[i].name;
            if (tests[i].together) begin
                id_a = add_worm(i, 1'b1);
                id_b = add_worm(i + 1, 1'b1);
                fork
                    send_worm(id_a);
                    send_worm(id_b);
                join
                i++;
            end else if (tests[i].hold) begin
                id_a = add_worm(i, 1'b0);
                base = out_cnt[tests[i].out_port];
                hold[tests[i].out_port] = 1'b1;
                fork
                    send_worm(id_a);
                    begin
                        repeat (12) @(posedge clk);
                        #1;
                        assert (out_cnt[tests[i].out_port] - base <= `ROUTER_QUEUE_DEPTH)
                            else fail_now($sformatf("** Error %s: expected at most 4 actual %0d",
                                cur_name, out_cnt[tests[i].out_port] - base));
                        hold[tests[i].out_port] = 1'b0;
                    end
                join
            end else begin
                id_a = add_worm(i, 1'b0);
                send_worm(id_a);
            end
            wait_idle();
            i++;
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the router testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module router_tb \
    -f verilog.f \
    --Mdir obj_dir -o router_sim

./obj_dir/router_sim

/* src/input_port.sv */
// Router input port with credit-sized FIFO, held worm route and next-hop routing
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module input_port (
    input  wire                     clk,
    input  wire                     rst,
    input  wire router_pkg::xy_t    position_i,
    input  wire router_pkg::flit_t  flit_i,
    input  wire                     flit_valid_i,
    input  wire                     pop_i,
    output router_pkg::flit_t       head_flit_o,
    output logic                    head_valid_o,
    output router_pkg::direction_t  route_req_o,
    output router_pkg::direction_t  next_route_o
);
    import router_pkg::*;

    localparam int PTR_W = $clog2(`ROUTER_QUEUE_DEPTH);

    flit_t                          fifo_mem [`ROUTER_QUEUE_DEPTH];
    logic [PTR_W-1:0]               wr_ptr;
    logic [PTR_W-1:0]               rd_ptr;
    credit_t                        count;
    logic                           full;
    logic                           push;
    logic                           valid_head;
    direction_t                     held_route;
    logic [`ROUTER_COORD_WIDTH-1:0] neighbor_x;
    logic [`ROUTER_COORD_WIDTH-1:0] dest_x;

    //////////////////////////////////////////////////////////////////////
    // Input FIFO
    //////////////////////////////////////////////////////////////////////

    assign full = (count == credit_t'(`ROUTER_QUEUE_DEPTH));
    assign push = flit_valid_i && !full;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= flit_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_flit_o  = fifo_mem[rd_ptr];
    assign head_valid_o = (count != '0);
    assign valid_head   = head_valid_o && head_flit_o.header.preamble.head;

    //////////////////////////////////////////////////////////////////////
    // Worm route and look-ahead
    //////////////////////////////////////////////////////////////////////

    // Route stays requested while the worm's payload drains
    always_ff @(posedge clk) begin
        if (rst) begin
            held_route <= '0;
        end else if (head_valid_o && pop_i && head_flit_o.header.preamble.tail) begin
            held_route <= '0;
        end else if (valid_head) begin
            held_route <= head_flit_o.header.routing;
        end
    end

    assign route_req_o = valid_head ? head_flit_o.header.routing : held_route;

    // Route the next router will take, judged from the tile this head enters
    always_comb begin
        dest_x       = head_flit_o.header.destination.x;
        neighbor_x   = position_i.x;
        next_route_o = '0;
        if (head_flit_o.header.routing[`ROUTER_PORT_EAST]) begin
            neighbor_x = position_i.x + 1'b1;
        end else if (head_flit_o.header.routing[`ROUTER_PORT_WEST]) begin
            neighbor_x = position_i.x - 1'b1;
        end
        if (head_flit_o.header.routing[`ROUTER_PORT_LOCAL] || dest_x == neighbor_x) begin
            next_route_o[`ROUTER_PORT_LOCAL] = 1'b1;
        end else if (dest_x > neighbor_x) begin
            next_route_o[`ROUTER_PORT_EAST] = 1'b1;
        end else begin
            next_route_o[`ROUTER_PORT_WEST] = 1'b1;
        end
    end

    // Upstream credit accounting keeps a full FIFO from being written
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        flit_valid_i |-> !full)
        else $error("input_port: flit written into a full FIFO");

endmodule

`default_nettype wire

/* src/lookahead_router.sv */
// Three-port look-ahead wormhole router for a row of NoC tiles
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module lookahead_router (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire router_pkg::xy_t                 position_i,
    input  wire router_pkg::flit_t               flit_east_i,
    input  wire router_pkg::flit_t               flit_west_i,
    input  wire router_pkg::flit_t               flit_local_i,
    input  wire [`ROUTER_NUM_PORTS-1:0]          flit_valid_i,
    output logic [`ROUTER_NUM_PORTS-1:0]         credit_o,
    output router_pkg::flit_t                    flit_east_o,
    output router_pkg::flit_t                    flit_west_o,
    output router_pkg::flit_t                    flit_local_o,
    output logic [`ROUTER_NUM_PORTS-1:0]         flit_valid_o,
    input  wire [`ROUTER_NUM_PORTS-1:0]          credit_i
);
    import router_pkg::*;

    localparam int NP = `ROUTER_NUM_PORTS;

    flit_t [NP-1:0]          flit_in;
    flit_t [NP-1:0]          flit_out;
    flit_t [NP-1:0]          head_flit;
    logic [NP-1:0]           head_valid;
    direction_t [NP-1:0]     route_req;
    direction_t [NP-1:0]     next_route;
    logic [NP-1:0][NP-1:0]   sel;
    logic [NP-1:0]           sel_valid;
    logic [NP-1:0]           insert_route;
    logic [NP-1:0]           pop;
    logic [NP-1:0]           can_send;

    assign flit_in[`ROUTER_PORT_EAST]  = flit_east_i;
    assign flit_in[`ROUTER_PORT_WEST]  = flit_west_i;
    assign flit_in[`ROUTER_PORT_LOCAL] = flit_local_i;

    assign flit_east_o  = flit_out[`ROUTER_PORT_EAST];
    assign flit_west_o  = flit_out[`ROUTER_PORT_WEST];
    assign flit_local_o = flit_out[`ROUTER_PORT_LOCAL];

    // One credit back upstream for every flit read from a FIFO
    assign credit_o = pop;

    for (genvar p = 0; p < NP; p++) begin : gen_port
        input_port u_input_port (
            .clk (clk), .rst (rst), .position_i (position_i),
            .flit_i (flit_in[p]), .flit_valid_i (flit_valid_i[p]), .pop_i (pop[p]),
            .head_flit_o (head_flit[p]), .head_valid_o (head_valid[p]),
            .route_req_o (route_req[p]), .next_route_o (next_route[p])
        );
        output_port u_output_port (
            .clk (clk), .rst (rst), .head_flit_i (head_flit), .next_route_i (next_route),
            .sel_i (sel[p]), .sel_valid_i (sel_valid[p]), .insert_route_i (insert_route[p]),
            .credit_i (credit_i[p]), .can_send_o (can_send[p]),
            .flit_o (flit_out[p]), .flit_valid_o (flit_valid_o[p])
        );
    end

    switch_allocator u_switch_allocator (
        .clk (clk), .rst (rst), .route_req_i (route_req), .head_valid_i (head_valid),
        .head_flit_i (head_flit), .can_send_i (can_send), .sel_o (sel),
        .sel_valid_o (sel_valid), .insert_route_o (insert_route), .pop_o (pop)
    );

endmodule

`default_nettype wire

/* src/output_port.sv */
// Router output port with flit mux, look-ahead route insertion and credit count
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module output_port (
    input  wire                                                  clk,
    input  wire                                                  rst,
    input  wire router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]      head_flit_i,
    input  wire router_pkg::direction_t [`ROUTER_NUM_PORTS-1:0] next_route_i,
    input  wire [`ROUTER_NUM_PORTS-1:0]                          sel_i,
    input  wire                                                  sel_valid_i,
    input  wire                                                  insert_route_i,
    input  wire                                                  credit_i,
    output logic                                                 can_send_o,
    output router_pkg::flit_t                                    flit_o,
    output logic                                                 flit_valid_o
);
    import router_pkg::*;

    flit_t      mux_flit;
    direction_t mux_route;
    credit_t    credits;
    logic       send;

    // AND-OR mux, the select is one-hot
    always_comb begin
        mux_flit  = '0;
        mux_route = '0;
        for (int i = 0; i < `ROUTER_NUM_PORTS; i++) begin
            if (sel_i[i]) begin
                mux_flit.raw = mux_flit.raw | head_flit_i[i].raw;
                mux_route    = mux_route | next_route_i[i];
            end
        end
    end

    // Head carries the route for the next hop
    always_comb begin
        flit_o = mux_flit;
        if (insert_route_i) begin
            flit_o.header.routing = mux_route;
        end
    end

    assign can_send_o   = (credits != '0);
    assign send         = sel_valid_i && can_send_o;
    assign flit_valid_o = send;

    //////////////////////////////////////////////////////////////////////
    // Downstream credits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(`ROUTER_QUEUE_DEPTH);
        end else begin
            case ({send, credit_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Downstream never returns more credits than flits it was sent
    a_credits_in_range: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_t'(`ROUTER_QUEUE_DEPTH))
        else $error("output_port: credit count above queue depth");

endmodule

`default_nettype wire

/* src/port_arbiter.sv */
// Round-robin arbiter between the two inputs that can reach one output
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
    input  wire        clk,
    input  wire        rst,
    input  wire  [1:0] request_i,
    input  wire        advance_i,
    output logic [1:0] grant_o,
    output logic       grant_valid_o
);
    // Set while input 1 holds the higher priority
    logic prio_hi;

    always_comb begin
        grant_o = 2'b00;
        if (prio_hi) begin
            if (request_i[1]) begin
                grant_o = 2'b10;
            end else if (request_i[0]) begin
                grant_o = 2'b01;
            end
        end else begin
            if (request_i[0]) begin
                grant_o = 2'b01;
            end else if (request_i[1]) begin
                grant_o = 2'b10;
            end
        end
    end

    assign grant_valid_o = |request_i;

    // Winner drops to low priority once its head is on the link
    always_ff @(posedge clk) begin
        if (rst) begin
            prio_hi <= 1'b0;
        end else if (advance_i) begin
            prio_hi <= grant_o[0];
        end
    end

endmodule

`default_nettype wire

/* src/router_consts.svh */
// Router constants for flit widths, queue depth and port numbering
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Flit payload bits, not counting the head/tail preamble
`define ROUTER_DATA_WIDTH 32

// Full flit on the link
`define ROUTER_FLIT_WIDTH 34

// Input FIFO depth, also the credit count a link starts with
`define ROUTER_QUEUE_DEPTH 4

// Header field widths
`define ROUTER_COORD_WIDTH 3
`define ROUTER_MESSAGE_WIDTH 5

// Port indices, shared by the one-hot route bits
`define ROUTER_PORT_EAST 0
`define ROUTER_PORT_WEST 1
`define ROUTER_PORT_LOCAL 2
`define ROUTER_NUM_PORTS 3

`endif

/* src/router_pkg.sv */
// Shared NoC types for tile coordinates, routes, head flits and link words
`default_nettype none

`include "router_consts.svh"

package router_pkg;

    typedef struct packed {
        logic [`ROUTER_COORD_WIDTH-1:0] x;
        logic [`ROUTER_COORD_WIDTH-1:0] y;
    } xy_t;

    // One-hot route, bit index equals the output port index
    typedef logic [`ROUTER_NUM_PORTS-1:0] direction_t;

    typedef struct packed {
        logic head;
        logic tail;
    } preamble_t;

    localparam int RESERVED_WIDTH = `ROUTER_DATA_WIDTH - 2 * $bits(xy_t)
                                    - `ROUTER_MESSAGE_WIDTH - $bits(direction_t);

    typedef struct packed {
        preamble_t                        preamble;
        xy_t                              source;
        xy_t                              destination;
        logic [`ROUTER_MESSAGE_WIDTH-1:0] message;
        logic [RESERVED_WIDTH-1:0]        reserved;
        direction_t                       routing;
    } header_t;

    // A head flit is read through the header, payload flits only as raw bits
    typedef union packed {
        header_t                       header;
        logic [`ROUTER_FLIT_WIDTH-1:0] raw;
    } flit_t;

    typedef logic [$clog2(`ROUTER_QUEUE_DEPTH + 1)-1:0] credit_t;

endpackage

`default_nettype wire

/* src/switch_allocator.sv */
// Switch allocator with per-output arbitration, wormhole lock and FIFO pops
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module switch_allocator (
    input  wire                                                  clk,
    input  wire                                                  rst,
    input  wire router_pkg::direction_t [`ROUTER_NUM_PORTS-1:0] route_req_i,
    input  wire [`ROUTER_NUM_PORTS-1:0]                          head_valid_i,
    input  wire router_pkg::flit_t [`ROUTER_NUM_PORTS-1:0]      head_flit_i,
    input  wire [`ROUTER_NUM_PORTS-1:0]                          can_send_i,
    output logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_NUM_PORTS-1:0]  sel_o,
    output logic [`ROUTER_NUM_PORTS-1:0]                         sel_valid_o,
    output logic [`ROUTER_NUM_PORTS-1:0]                         insert_route_o,
    output logic [`ROUTER_NUM_PORTS-1:0]                         pop_o
);
    import router_pkg::*;

    localparam int NP = `ROUTER_NUM_PORTS;

    // A flit leaves on this output in the current cycle
    logic [NP-1:0] forward;

    for (genvar o = 0; o < NP; o++) begin : gen_output
        // The two inputs other than this port, lower index first
        localparam int IN_A = (o == 0) ? 1 : 0;
        localparam int IN_B = (o == NP - 1) ? NP - 2 : NP - 1;

        logic [1:0]    request;
        logic [1:0]    grant;
        logic          grant_valid;
        logic          busy;
        logic [1:0]    locked_sel;
        logic [1:0]    cur_sel;
        logic [NP-1:0] sel_vec;
        flit_t         sel_flit;

        assign request = {route_req_i[IN_B][o], route_req_i[IN_A][o]};

        port_arbiter u_port_arbiter (
            .clk           (clk),
            .rst           (rst),
            .request_i     (request),
            .advance_i     (forward[o] && !busy),
            .grant_o       (grant),
            .grant_valid_o (grant_valid)
        );

        // Payload flits follow the input saved with the head
        assign cur_sel = busy ? locked_sel : grant;

        always_comb begin
            sel_vec       = '0;
            sel_vec[IN_A] = cur_sel[0];
            sel_vec[IN_B] = cur_sel[1];
        end

        assign sel_flit          = cur_sel[1] ? head_flit_i[IN_B] : head_flit_i[IN_A];
        assign sel_o[o]          = sel_vec;
        assign sel_valid_o[o]    = (busy || grant_valid) && |(sel_vec & head_valid_i);
        assign forward[o]        = sel_valid_o[o] && can_send_i[o];
        assign insert_route_o[o] = !busy;

        // Lock taken on a head without tail, released when the tail leaves
        always_ff @(posedge clk) begin
            if (rst) begin
                busy <= 1'b0;
            end else if (forward[o]) begin
                busy <= !sel_flit.header.preamble.tail;
            end
        end

        always_ff @(posedge clk) begin
            if (forward[o] && !busy) begin
                locked_sel <= grant;
            end
        end

        //////////////////////////////////////////////////////////////////////
        // Checks
        //////////////////////////////////////////////////////////////////////

        a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
            $onehot0(sel_vec))
            else $error("switch_allocator: output %0d selects several inputs", o);

        a_no_self_route: assert property (@(posedge clk) disable iff (rst)
            !route_req_i[o][o])
            else $error("switch_allocator: input %0d routed back to itself", o);

        a_head_expected: assert property (@(posedge clk) disable iff (rst)
            forward[o] && !busy |-> sel_flit.header.preamble.head)
            else $error("switch_allocator: output %0d opened a worm without a head", o);
    end

    // Each input is read by the output that forwards its flit
    always_comb begin
        pop_o = '0;
        for (int o = 0; o < NP; o++) begin
            if (forward[o]) begin
                pop_o = pop_o | sel_o[o];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
+incdir+bench
src/router_pkg.sv
src/input_port.sv
src/port_arbiter.sv
src/switch_allocator.sv
src/output_port.sv
src/lookahead_router.sv
bench/router_tb.sv
